// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert --top-module tb_cam_usb_bridge \
		-f sources.f -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "^Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: source/cam_stream_pkg.sv
package cam_stream_pkg;

  // ==========================================================
  // Stream widths
  // ==========================================================
  localparam int CAM_BYTE_W = 8;  // OV5640 parallel data bus
  localparam int PIX_W      = 16;  // One RGB565 pixel

  // ==========================================================
  // FIFO sizing
  // ==========================================================
  localparam int FIFO_DEPTH_WORDS = 2048;  // Capacity in pixel words
  localparam int FIFO_AW          = $clog2(FIFO_DEPTH_WORDS);  // Word address bits
  localparam int FIFO_BYTES       = 2 * FIFO_DEPTH_WORDS;  // Capacity in bytes
  localparam int FIFO_AF_WORDS    = 2032;  // Almost-full level in words
  localparam int FIFO_CNT_W       = 13;  // Byte count up to 4096
  localparam int PACKET_BYTES     = 512;  // One USB bulk packet

  // ==========================================================
  // Frame marker and debug rate
  // ==========================================================
  localparam logic [PIX_W-1:0] MARKER_WORD = 16'h0001;  // Start of frame tag
  localparam int MARKER_LAST  = 1000;  // Counter runs 0..1000
  localparam int MARKER_CNT_W = $clog2(MARKER_LAST + 1);

  localparam int RATE_HALF_PERIOD = 256;  // Words per toggle
  localparam int RATE_CNT_W       = $clog2(RATE_HALF_PERIOD);

  // Pixel word as it comes off the camera bus
  typedef struct packed {
    logic [4:0] top5;  // Bits 15..11
    logic [5:0] mid6;  // Bits 10..5
    logic [4:0] low5;  // Bits 4..0
  } cam_fields_t;

  typedef union packed {
    logic [PIX_W-1:0] raw;  // First byte in the high half
    cam_fields_t      cam_fields;  // Channel split of the same bits
  } pixel_word_u;

endpackage

// File: source/cam_usb_bridge.sv
module cam_usb_bridge import cam_stream_pkg::*; (
  input  logic                  cmos_pclk,  // Camera pixel clock
  input  logic                  I_rst_n,
  input  logic                  cmos_vsync_i,
  input  logic                  cmos_href_i,
  input  logic [CAM_BYTE_W-1:0] cmos_db_i,
  input  logic                  usb_pop_i,
  output logic [CAM_BYTE_W-1:0] usb_byte_o,
  output logic                  usb_byte_valid_o,
  output logic                  fifo_full_o,
  output logic                  fifo_almost_full_o,
  output logic                  rate_tick_o  // Pixel activity
);

  logic [PIX_W-1:0] pix_word;  // Capture to marker
  logic             pix_valid;
  logic [PIX_W-1:0] wr_word;  // Marker to FIFO
  logic             wr_en;
  logic             fifo_af;  // Back-pressure to marker

  // ==========================================================
  // Camera side
  // ==========================================================
  pixel_capture pixel_capture_i (
    .cmos_pclk   (cmos_pclk),
    .I_rst_n     (I_rst_n),
    .cmos_href_i (cmos_href_i),
    .cmos_db_i   (cmos_db_i),
    .pix_word_o  (pix_word),
    .pix_valid_o (pix_valid),
    .rate_tick_o (rate_tick_o)
  );

  frame_marker frame_marker_i (
    .cmos_pclk     (cmos_pclk),
    .I_rst_n       (I_rst_n),
    .cmos_vsync_i  (cmos_vsync_i),
    .pix_word_i    (pix_word),
    .pix_valid_i   (pix_valid),
    .almost_full_i (fifo_af),
    .wr_word_o     (wr_word),
    .wr_en_o       (wr_en)
  );

  // ==========================================================
  // Buffer toward USB
  // ==========================================================
  packet_fifo packet_fifo_i (
    .cmos_pclk        (cmos_pclk),
    .I_rst_n          (I_rst_n),
    .wr_word_i        (wr_word),
    .wr_en_i          (wr_en),
    .usb_pop_i        (usb_pop_i),
    .usb_byte_o       (usb_byte_o),
    .usb_byte_valid_o (usb_byte_valid_o),
    .full_o           (fifo_full_o),
    .almost_full_o    (fifo_af)
  );

  assign fifo_almost_full_o = fifo_af;  // Status pin

endmodule

// File: source/frame_marker.sv
module frame_marker import cam_stream_pkg::*; (
  input  logic             cmos_pclk,
  input  logic             I_rst_n,
  input  logic             cmos_vsync_i,  // Frame sync from camera
  input  logic [PIX_W-1:0] pix_word_i,  // Captured pixel
  input  logic             pix_valid_i,  // Pixel strobe
  input  logic             almost_full_i,  // FIFO back-pressure
  output logic [PIX_W-1:0] wr_word_o,  // FIFO write data
  output logic             wr_en_o  // FIFO write strobe
);

  logic                    vsync_q;  // Vsync one cycle back
  logic                    vsync_rise;
  logic                    marker_active;  // Marker block in progress
  logic [MARKER_CNT_W-1:0] marker_cnt;  // Marker words written so far

  assign vsync_rise = cmos_vsync_i & ~vsync_q;

  // ==========================================================
  // Marker state
  // ==========================================================
  always_ff @(posedge cmos_pclk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      vsync_q       <= 1'b0;
      marker_active <= 1'b0;
      marker_cnt    <= '0;
    end else begin
      vsync_q <= cmos_vsync_i;  // Edge history
      if (vsync_rise && !marker_active && !almost_full_i) begin
        marker_active <= 1'b1;  // New frame
        marker_cnt    <= '0;
      end else if (marker_active && !almost_full_i) begin
        if (marker_cnt < MARKER_CNT_W'(MARKER_LAST)) begin
          marker_cnt <= marker_cnt + 1'b1;  // One marker word out
        end else begin
          marker_active <= 1'b0;  // Last word written this cycle
        end
      end
    end
  end

  // ==========================================================
  // Write port mux
  // ==========================================================
  // Pixels lose the port while the marker runs
  assign wr_word_o = marker_active ? MARKER_WORD : pix_word_i;
  assign wr_en_o   = ~almost_full_i & (marker_active | pix_valid_i);  // Drop, never stall

  a_no_write_af : assert property (
    @(posedge cmos_pclk) disable iff (!I_rst_n)
    wr_en_o |-> !almost_full_i
  ) else $error("FIFO write while almost full");

endmodule

// File: source/packet_fifo.sv
module packet_fifo import cam_stream_pkg::*; (
  input  logic                  cmos_pclk,
  input  logic                  I_rst_n,
  input  logic [PIX_W-1:0]      wr_word_i,  // Word from marker mux
  input  logic                  wr_en_i,
  input  logic                  usb_pop_i,  // Level request from USB side
  output logic [CAM_BYTE_W-1:0] usb_byte_o,  // Byte toward USB
  output logic                  usb_byte_valid_o,
  output logic                  full_o,
  output logic                  almost_full_o
);

  logic [PIX_W-1:0]      mem [FIFO_DEPTH_WORDS];  // Word storage
  logic [FIFO_AW-1:0]    wr_ptr;  // Word write address
  logic [FIFO_AW:0]      rd_ptr;  // Word address over byte select
  logic [FIFO_CNT_W-1:0] byte_cnt;  // Bytes waiting
  logic                  empty;
  logic                  pkt_ready;  // A whole packet is buffered
  logic                  wr_fire;
  logic                  rd_fire;
  logic [PIX_W-1:0]      rd_word;  // Word under the read pointer

  // ==========================================================
  // Flags from the byte count
  // ==========================================================
  assign empty         = (byte_cnt == '0);
  assign full_o        = byte_cnt > FIFO_CNT_W'(FIFO_BYTES - 2);  // No room for a word
  assign almost_full_o = byte_cnt >= FIFO_CNT_W'(2 * FIFO_AF_WORDS);
  assign pkt_ready     = byte_cnt >= FIFO_CNT_W'(PACKET_BYTES);

  assign wr_fire = wr_en_i & ~full_o;
  assign rd_fire = usb_pop_i & ~empty & pkt_ready;  // Packet gate
  assign rd_word = mem[rd_ptr[FIFO_AW:1]];

  // ==========================================================
  // Storage and pointers
  // ==========================================================
  always_ff @(posedge cmos_pclk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= wr_word_i;
    end
  end

  always_ff @(posedge cmos_pclk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      byte_cnt <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr <= rd_ptr + 1'b1;  // Steps bytes
      end
      case ({wr_fire, rd_fire})
        2'b10:   byte_cnt <= byte_cnt + FIFO_CNT_W'(2);  // Word in
        2'b01:   byte_cnt <= byte_cnt - FIFO_CNT_W'(1);  // Byte out
        2'b11:   byte_cnt <= byte_cnt + FIFO_CNT_W'(1);  // Both
        default: byte_cnt <= byte_cnt;
      endcase
    end
  end

  // ==========================================================
  // Output byte
  // ==========================================================
  always_ff @(posedge cmos_pclk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      usb_byte_valid_o <= 1'b0;
    end else begin
      usb_byte_valid_o <= rd_fire;
    end
  end

  // Low byte of each word leaves first
  always_ff @(posedge cmos_pclk) begin
    if (rd_fire) begin
      usb_byte_o <= rd_ptr[0] ? rd_word[PIX_W-1:CAM_BYTE_W] : rd_word[CAM_BYTE_W-1:0];
    end
  end

  a_no_write_full : assert property (
    @(posedge cmos_pclk) disable iff (!I_rst_n)
    wr_en_i |-> !full_o
  ) else $error("Write into full FIFO");

  // Every byte seen at the output came from a full packet
  a_pkt_gate : assert property (
    @(posedge cmos_pclk) disable iff (!I_rst_n)
    usb_byte_valid_o |-> $past(byte_cnt) >= FIFO_CNT_W'(PACKET_BYTES)
  ) else $error("Byte read below packet level");

endmodule

// File: source/pixel_capture.sv
module pixel_capture import cam_stream_pkg::*; (
  input  logic                  cmos_pclk,
  input  logic                  I_rst_n,
  input  logic                  cmos_href_i,  // Line valid
  input  logic [CAM_BYTE_W-1:0] cmos_db_i,  // Camera byte
  output logic [PIX_W-1:0]      pix_word_o,  // Reordered RGB565
  output logic                  pix_valid_o,  // One strobe per word
  output logic                  rate_tick_o  // Activity toggle
);

  logic                  byte_phase;  // High while expecting second byte
  logic [CAM_BYTE_W-1:0] first_byte;  // Held high byte of the pair
  pixel_word_u           pair_word;  // Both bytes side by side
  logic                  word_done;  // Second byte on the bus
  logic [RATE_CNT_W-1:0] rate_cnt;  // Words since last toggle

  // ==========================================================
  // Byte pairing
  // ==========================================================
  assign pair_word.raw = {first_byte, cmos_db_i};  // First byte high
  assign word_done     = cmos_href_i & byte_phase;

  always_ff @(posedge cmos_pclk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      byte_phase <= 1'b0;
    end else if (!cmos_href_i) begin
      byte_phase <= 1'b0;  // Realign at every line gap
    end else begin
      byte_phase <= ~byte_phase;
    end
  end

  always_ff @(posedge cmos_pclk) begin
    if (cmos_href_i && !byte_phase) begin
      first_byte <= cmos_db_i;  // Capture first half
    end
  end

  // ==========================================================
  // Word output with channel swap
  // ==========================================================
  always_ff @(posedge cmos_pclk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      pix_valid_o <= 1'b0;
    end else begin
      pix_valid_o <= word_done;  // Lags second byte by one cycle
    end
  end

  // Low field to top, top field to bottom
  always_ff @(posedge cmos_pclk) begin
    if (word_done) begin
      pix_word_o <= {pair_word.cam_fields.low5,
                     pair_word.cam_fields.mid6,
                     pair_word.cam_fields.top5};
    end
  end

  // ==========================================================
  // Activity toggle
  // ==========================================================
  always_ff @(posedge cmos_pclk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      rate_cnt    <= '0;
      rate_tick_o <= 1'b0;
    end else if (word_done) begin
      if (rate_cnt == RATE_CNT_W'(RATE_HALF_PERIOD - 1)) begin
        rate_cnt    <= '0;  // Wrap
        rate_tick_o <= ~rate_tick_o;  // Half period done
      end else begin
        rate_cnt <= rate_cnt + 1'b1;
      end
    end
  end

  // Pairing means a word needs at least two bus cycles
  a_valid_spaced : assert property (
    @(posedge cmos_pclk) disable iff (!I_rst_n)
    pix_valid_o |=> !pix_valid_o
  ) else $error("pix_valid_o high on consecutive cycles");

endmodule

// File: sources.f
source/cam_stream_pkg.sv
source/pixel_capture.sv
source/frame_marker.sv
source/packet_fifo.sv
source/cam_usb_bridge.sv
tests/tb_clock.sv
tests/tb_cam_usb_bridge.sv

// File: tests/stream_trace.txt
# Columns: command, then hex or decimal arguments
# T name | P byte1 byte2 expected_word | G cycles (0 random) | F pairs | V | Z | D | H | Q | M | X | R
T reset
Q
G 3
T packet_gate
P 12 34 a222
P ff 00 071f
G 0
P 00 ff f8e0
G 4
Z 20
T pixel_order
P f8 00 001f
P 00 1f f800
G 0
P 07 e0 07e0
P ab cd 6bd5
G 0
P 55 aa 55aa
P 12 34 a222
G 2
F 300
G 0
D 3000
T frame_marker
V
F 40
G 10
G 0
D 6000
M 1001
P ab cd 6bd5
P 00 ff f8e0
G 0
T backpressure
F 2100
H 50
X
G 0
D 12000
T rate_tick
F 260
G 0
D 3000
R

// File: tests/tb_cam_usb_bridge.sv
module tb_cam_usb_bridge import cam_stream_pkg::*; ();

  localparam int      CLK_PERIOD  = 100;
  localparam int      DRIVE_DELAY = 10;  // After the rising edge
  localparam logic [31:0] SEED    = 32'hb810;
  localparam int      RST_TIMEOUT = 20;  // Cycles

  logic                  cmos_pclk;
  logic                  I_rst_n;
  logic                  cmos_vsync;
  logic                  cmos_href;
  logic [CAM_BYTE_W-1:0] cmos_db;
  logic                  usb_pop;
  logic [CAM_BYTE_W-1:0] usb_byte;
  logic                  usb_byte_valid;
  logic                  fifo_full;
  logic                  fifo_almost_full;
  logic                  rate_tick;

  // Reference model state
  logic [7:0]  fifo_q[$];  // Bytes held in the model FIFO
  logic [7:0]  exp_q[$];  // Bytes read, waiting for the DUT
  logic [15:0] pend_q[$];  // Expected reordered words in flight
  logic        m_phase;
  logic        m_pv;
  logic [15:0] m_pword;
  logic        m_vq;
  logic        m_mact;
  int          m_mcnt;
  int          m_words;  // Completed words since reset
  logic        m_tick;
  int          m_dropped;
  int          m_marker_words;

  // Scoreboard counters
  int          err_cnt;
  int          check_cnt;
  int          test_cnt;
  int          valid_seen;
  int          tick_toggles;
  logic        tick_prev;
  int          test_err0;
  string       test_name;

  tb_clock #(.PERIOD(CLK_PERIOD)) tb_clock_i (
    .clk_o   (cmos_pclk),
    .rst_n_o (I_rst_n)
  );

  cam_usb_bridge cam_usb_bridge_i (
    .cmos_pclk          (cmos_pclk),
    .I_rst_n            (I_rst_n),
    .cmos_vsync_i       (cmos_vsync),
    .cmos_href_i        (cmos_href),
    .cmos_db_i          (cmos_db),
    .usb_pop_i          (usb_pop),
    .usb_byte_o         (usb_byte),
    .usb_byte_valid_o   (usb_byte_valid),
    .fifo_full_o        (fifo_full),
    .fifo_almost_full_o (fifo_almost_full),
    .rate_tick_o        (rate_tick)
  );

  // Camera channel swap, low field to top
  function automatic logic [15:0] swap_channels(input logic [15:0] w);
    return {w[4:0], w[10:5], w[15:11]};
  endfunction

  // ==========================================================
  // Reference model, one step per rising edge
  // ==========================================================
  task automatic model_step();
    logic af;
    logic rd;
    logic wr;
    logic word_done;
    logic [15:0] wdata;
    af = fifo_q.size() >= 2 * FIFO_AF_WORDS;
    rd = usb_pop && fifo_q.size() > 0 && fifo_q.size() >= PACKET_BYTES;  // Packet gate
    wr = !af && (m_mact || m_pv);
    wdata = m_mact ? MARKER_WORD : m_pword;
    if (m_pv && (m_mact || af)) m_dropped++;  // Lost pixel
    if (wr && m_mact) m_marker_words++;
    if (rd) exp_q.push_back(fifo_q.pop_front());
    if (wr) begin
      fifo_q.push_back(wdata[7:0]);  // Low byte leaves first
      fifo_q.push_back(wdata[15:8]);
    end
    if (cmos_vsync && !m_vq && !m_mact && !af) begin
      m_mact = 1'b1;
      m_mcnt = 0;
    end else if (m_mact && !af) begin
      if (m_mcnt < MARKER_LAST) m_mcnt++;
      else m_mact = 1'b0;  // 1001 words done
    end
    m_vq = cmos_vsync;
    word_done = cmos_href && m_phase;
    m_pv = word_done;
    if (word_done) begin
      if (pend_q.size() == 0) begin
        $display("model error at %0t: pixel completed with no expected word", $time);
        err_cnt++;
        m_pword = 16'h0;
      end else begin
        m_pword = pend_q.pop_front();
      end
      m_words++;
      if (m_words % RATE_HALF_PERIOD == 0) m_tick = ~m_tick;
    end
    m_phase = cmos_href ? !m_phase : 1'b0;
  endtask

  always @(posedge cmos_pclk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      fifo_q.delete();
      exp_q.delete();
      m_phase = 1'b0;
      m_pv = 1'b0;
      m_pword = 16'h0;
      m_vq = 1'b0;
      m_mact = 1'b0;
      m_mcnt = 0;
      m_words = 0;
      m_tick = 1'b0;
      m_dropped = 0;
      m_marker_words = 0;
    end else begin
      model_step();
    end
  end

  // ==========================================================
  // Scoreboard on the falling edge, outputs settled
  // ==========================================================
  task automatic check_bit(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  always @(negedge cmos_pclk) begin
    if (I_rst_n) begin
      if (usb_byte_valid) begin
        valid_seen++;
        check_cnt++;
        if (exp_q.size() == 0) begin
          $display("error at %0t: DUT sent a byte the model did not expect", $time);
          err_cnt++;
        end else if (usb_byte !== exp_q[0]) begin
          $display("mismatch at %0t: usb_byte_o got %h expected %h", $time, usb_byte,
                   exp_q[0]);
          err_cnt++;
          void'(exp_q.pop_front());
        end else begin
          void'(exp_q.pop_front());
        end
      end
      check_bit("fifo_full_o", fifo_full, 1'b0);  // Never reached by traffic
      check_bit("fifo_almost_full_o", fifo_almost_full,
                fifo_q.size() >= 2 * FIFO_AF_WORDS);
      check_bit("rate_tick_o", rate_tick, m_tick);
      if (rate_tick !== tick_prev) tick_toggles++;
      tick_prev = rate_tick;
    end
  end

  // ==========================================================
  // Stimulus tasks
  // ==========================================================
  task automatic next_cycle();
    @(posedge cmos_pclk);
    #DRIVE_DELAY;
  endtask

  task automatic send_pair(input logic [7:0] b1, input logic [7:0] b2,
                           input logic [15:0] exp_word);
    pend_q.push_back(exp_word);
    cmos_href = 1'b1;
    cmos_db = b1;
    next_cycle();
    cmos_db = b2;
    next_cycle();
  endtask

  task automatic idle(input int n);
    cmos_href = 1'b0;
    cmos_db = 8'h00;
    repeat (n) next_cycle();
  endtask

  // Generated pixels, bytes follow the index
  task automatic send_block(input int n);
    logic [15:0] idx;
    logic [7:0]  b1;
    logic [7:0]  b2;
    for (int i = 0; i < n; i++) begin
      idx = 16'(i);
      b1 = idx[7:0] ^ 8'h5a;
      b2 = idx[15:8] + idx[7:0];
      send_pair(b1, b2, swap_channels({b1, b2}));
    end
    idle(1);
  endtask

  task automatic pulse_vsync();
    cmos_vsync = 1'b1;
    idle(2);
    cmos_vsync = 1'b0;
    next_cycle();
  endtask

  task automatic drain(input int limit);
    int i;
    i = 0;
    usb_pop = 1'b1;
    while (!(exp_q.size() == 0 && fifo_q.size() < PACKET_BYTES && !m_mact && !m_pv)
           && i < limit) begin
      next_cycle();
      i++;
    end
    if (i >= limit) begin
      $display("timeout at %0t: FIFO did not drain in %0d cycles", $time, limit);
      err_cnt++;
    end
    usb_pop = 1'b0;
    idle(3);
  endtask

  task automatic wait_almost_full(input int limit);
    int i;
    i = 0;
    while (fifo_almost_full !== 1'b1 && i < limit) begin
      next_cycle();
      i++;
    end
    if (i >= limit) begin
      $display("timeout at %0t: fifo_almost_full_o never rose", $time);
      err_cnt++;
    end
  endtask

  task automatic pop_without_packet(input int n);
    int seen0;
    seen0 = valid_seen;
    idle(1);
    usb_pop = 1'b1;
    repeat (n) next_cycle();
    usb_pop = 1'b0;
    idle(2);
    check_cnt++;
    if (valid_seen != seen0) begin
      $display("error at %0t: bytes came out below a full packet", $time);
      err_cnt++;
    end
  endtask

  task automatic finish_test();
    if (test_name.len() > 0) begin
      test_cnt++;
      if (err_cnt == test_err0) $display("test %s: ok", test_name);
      else $display("test %s: failed with %0d errors", test_name, err_cnt - test_err0);
    end
  endtask

  task automatic check_int(input string name, input int got, input int exp);
    check_cnt++;
    if (got != exp) begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // ==========================================================
  // Trace interpreter
  // ==========================================================
  initial begin
    int    fd;
    int    n;
    int    a1;
    int    a2;
    int    a3;
    string line;
    string cmd;
    cmos_vsync = 1'b0;
    cmos_href = 1'b0;
    cmos_db = 8'h00;
    usb_pop = 1'b0;
    err_cnt = 0;
    check_cnt = 0;
    test_cnt = 0;
    valid_seen = 0;
    tick_toggles = 0;
    tick_prev = 1'b0;
    test_err0 = 0;
    test_name = "";
    void'($urandom(SEED));
    n = 0;
    while (I_rst_n !== 1'b1 && n < RST_TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (n >= RST_TIMEOUT) begin
      $display("timeout: reset never released");
      err_cnt++;
    end
    fd = $fopen("tests/stream_trace.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open tests/stream_trace.txt");
      err_cnt++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() < 2 || line.getc(0) == "#") continue;
        void'($sscanf(line, "%s", cmd));
        case (cmd)
          "T": begin
            finish_test();
            void'($sscanf(line, "%s %s", cmd, test_name));
            test_err0 = err_cnt;
            m_dropped = 0;  // Drops counted per test
          end
          "P": begin
            void'($sscanf(line, "%s %h %h %h", cmd, a1, a2, a3));
            send_pair(8'(a1), 8'(a2), 16'(a3));
          end
          "G": begin
            void'($sscanf(line, "%s %d", cmd, a1));
            if (a1 == 0) a1 = 1 + int'($urandom % 8);  // Random gap
            idle(a1);
          end
          "F": begin
            void'($sscanf(line, "%s %d", cmd, a1));
            send_block(a1);
          end
          "V": pulse_vsync();
          "Z": begin
            void'($sscanf(line, "%s %d", cmd, a1));
            pop_without_packet(a1);
          end
          "D": begin
            void'($sscanf(line, "%s %d", cmd, a1));
            drain(a1);
          end
          "H": begin
            void'($sscanf(line, "%s %d", cmd, a1));
            wait_almost_full(a1);
          end
          "Q": begin
            check_bit("usb_byte_valid_o", usb_byte_valid, 1'b0);
            check_bit("fifo_full_o", fifo_full, 1'b0);
            check_bit("fifo_almost_full_o", fifo_almost_full, 1'b0);
            check_bit("rate_tick_o", rate_tick, 1'b0);
          end
          "M": begin
            void'($sscanf(line, "%s %d", cmd, a1));
            check_int("marker words", m_marker_words, a1);
            m_marker_words = 0;
          end
          "X": begin
            check_cnt++;
            if (m_dropped == 0) begin
              $display("error at %0t: no pixels were dropped at almost full", $time);
              err_cnt++;
            end
          end
          "R": check_int("rate_tick_o toggles", tick_toggles, m_words / RATE_HALF_PERIOD);
          default: begin
            $display("error: unknown trace command %s", cmd);
            err_cnt++;
          end
        endcase
      end
      $fclose(fd);
      finish_test();
    end
    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: tests/tb_clock.sv
module tb_clock #(
  parameter int PERIOD = 100  // Clock period in time units
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;  // Free running
  end

  // Reset held over the first three rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    #10;
    rst_n_o = 1'b1;  // Released off the edge
  end

endmodule
